//--- rtl/zombie_settings.svh
`ifndef ZOMBIE_SETTINGS_SVH
`define ZOMBIE_SETTINGS_SVH

// 640x480 at 60 Hz, 25 MHz pixel clock.
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

// Square sprite, one texel per pixel.
`define SPRITE_SIZE 32
`define ZOMBIE_COUNT 3

`define COORD_WIDTH 10
`define SPRITE_ADDR_WIDTH 10

`endif

//--- rtl/zombieTypes_pkg.sv
`default_nettype none

`include "zombie_settings.svh"

package zombieTypes_pkg;

  typedef enum logic [1:0] {
    FACE_UP    = 2'd0,
    FACE_RIGHT = 2'd1,
    FACE_DOWN  = 2'd2,
    FACE_LEFT  = 2'd3
  } zombieFace_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  localparam rgb_t COLOR_WHITE = 24'hFFFFFF;
  localparam rgb_t COLOR_BLACK = 24'h000000;

  typedef struct packed {
    logic [`COORD_WIDTH-1:0] x; // Top left corner of the box.
    logic [`COORD_WIDTH-1:0] y;
    zombieFace_t face;
    logic live;
  } zombieState_t;

  typedef struct packed {
    logic we;
    zombieFace_t face; // Selects the target RAM.
    logic [`SPRITE_ADDR_WIDTH-1:0] addr;
    rgb_t data;
  } spriteWrite_t;

  typedef struct packed {
    logic [`COORD_WIDTH-1:0] x;
    logic [`COORD_WIDTH-1:0] y;
    logic hsync; // Active low.
    logic vsync;
    logic blank;
  } scanPos_t;

  typedef struct packed {
    scanPos_t pos;
    rgb_t color;
  } pixelOut_t;

endpackage

`default_nettype wire

//--- rtl/vgaScanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "zombie_settings.svh"

module vgaScanner (
  input  logic Clk,
  input  logic rst,
  output zombieTypes_pkg::scanPos_t scan
);

  localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
  localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;

  localparam zombieTypes_pkg::scanPos_t SCAN_START = '{
    x:     '0,
    y:     '0,
    hsync: 1'b1,
    vsync: 1'b1,
    blank: 1'b0
  };

  zombieTypes_pkg::scanPos_t scanNext;

  // Sync and blank come from the next counter values so that
  // every field of scan is registered on the same edge.
  always_comb
  begin
    scanNext.x = scan.x + 1'b1;
    scanNext.y = scan.y;
    if (scan.x == `COORD_WIDTH'(`H_TOTAL - 1))
    begin
      scanNext.x = '0; // End of line.
      if (scan.y == `COORD_WIDTH'(`V_TOTAL - 1))
        scanNext.y = '0;
      else
        scanNext.y = scan.y + 1'b1;
    end

    scanNext.hsync = !((scanNext.x >= `COORD_WIDTH'(H_SYNC_START)) &&
                       (scanNext.x < `COORD_WIDTH'(H_SYNC_END)));
    scanNext.vsync = !((scanNext.y >= `COORD_WIDTH'(V_SYNC_START)) &&
                       (scanNext.y < `COORD_WIDTH'(V_SYNC_END)));
    scanNext.blank = (scanNext.x >= `COORD_WIDTH'(`H_ACTIVE)) ||
                     (scanNext.y >= `COORD_WIDTH'(`V_ACTIVE));
  end

  always_ff @(posedge Clk)
  begin
    if (rst)
      scan <= SCAN_START;
    else
      scan <= scanNext;
  end

  // Counters never leave the frame.
  scanInFrame: assert property (@(posedge Clk) disable iff (rst)
    (scan.x < `COORD_WIDTH'(`H_TOTAL)) && (scan.y < `COORD_WIDTH'(`V_TOTAL)));

endmodule

`default_nettype wire

//--- rtl/spriteRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "zombie_settings.svh"

module spriteRam #(
  parameter zombieTypes_pkg::zombieFace_t FACE = zombieTypes_pkg::FACE_UP
) (
  input  logic Clk,
  input  zombieTypes_pkg::spriteWrite_t spriteLoad,
  input  logic [`SPRITE_ADDR_WIDTH-1:0] readAddr,
  output zombieTypes_pkg::rgb_t readData
);

  localparam int DEPTH = `SPRITE_SIZE * `SPRITE_SIZE;

  zombieTypes_pkg::rgb_t mem [DEPTH];

  logic writeHit;

  assign writeHit = spriteLoad.we && (spriteLoad.face == FACE);

  // Read first, so a same-address write shows up one cycle later.
  always_ff @(posedge Clk)
  begin
    if (writeHit)
      mem[spriteLoad.addr] <= spriteLoad.data;
    readData <= mem[readAddr];
  end

  // Shared load bus must carry a clean address on every strobe.
  loadAddrKnown: assert property (@(posedge Clk)
    spriteLoad.we |-> !$isunknown(spriteLoad.addr));

endmodule

`default_nettype wire

//--- rtl/zombieSpriteTable.sv
`timescale 1ns/1ps
`default_nettype none

`include "zombie_settings.svh"

module zombieSpriteTable (
  input  logic Clk,
  input  logic rst,
  input  zombieTypes_pkg::scanPos_t scan,
  input  zombieTypes_pkg::zombieState_t zombies [`ZOMBIE_COUNT],
  input  zombieTypes_pkg::spriteWrite_t spriteLoad,
  output logic isZombie,
  output zombieTypes_pkg::rgb_t spriteColor
);

  localparam int FACE_COUNT = 2 ** $bits(zombieTypes_pkg::zombieFace_t);

  logic [`COORD_WIDTH-1:0] colOff [`ZOMBIE_COUNT];
  logic [`COORD_WIDTH-1:0] rowOff [`ZOMBIE_COUNT];
  logic inBox [`ZOMBIE_COUNT];

  logic hitFound;
  logic hitLive;
  zombieTypes_pkg::zombieFace_t hitFace;
  zombieTypes_pkg::zombieFace_t faceReg;
  logic [`SPRITE_ADDR_WIDTH-1:0] readAddr;
  zombieTypes_pkg::rgb_t faceColor [FACE_COUNT];

  for (genvar i = 0; i < `ZOMBIE_COUNT; i++)
  begin : gBox
    assign colOff[i] = scan.x - zombies[i].x;
    assign rowOff[i] = scan.y - zombies[i].y;
    // Offsets are only meaningful once the corner is passed.
    assign inBox[i] = (scan.x >= zombies[i].x) && (scan.y >= zombies[i].y) &&
                      (colOff[i] < `COORD_WIDTH'(`SPRITE_SIZE)) &&
                      (rowOff[i] < `COORD_WIDTH'(`SPRITE_SIZE));
  end

  // Lowest index wins, dead or alive.
  always_comb
  begin
    hitFound = 1'b0;
    hitLive = 1'b0;
    hitFace = zombieTypes_pkg::FACE_UP;
    readAddr = '0;
    for (int i = 0; i < `ZOMBIE_COUNT; i++)
    begin
      if (inBox[i] && !hitFound)
      begin
        hitFound = 1'b1;
        hitLive = zombies[i].live;
        hitFace = zombies[i].face;
        readAddr = `SPRITE_ADDR_WIDTH'(rowOff[i] * `SPRITE_SIZE + colOff[i]);
      end
    end
  end

  // Aligned with the RAM read below.
  always_ff @(posedge Clk)
  begin
    if (rst)
      isZombie <= 1'b0;
    else
      isZombie <= hitFound && hitLive;
  end

  always_ff @(posedge Clk)
  begin
    faceReg <= hitFace;
  end

  for (genvar f = 0; f < FACE_COUNT; f++)
  begin : gFaceRam
    spriteRam #(
      .FACE(zombieTypes_pkg::zombieFace_t'(f))
    ) faceRam (
      .Clk(Clk),
      .spriteLoad(spriteLoad),
      .readAddr(readAddr),
      .readData(faceColor[f])
    );
  end

  always_comb
  begin
    if (isZombie)
      spriteColor = faceColor[faceReg];
    else
      spriteColor = zombieTypes_pkg::COLOR_WHITE; // Background.
  end

  // A visible zombie reads only loaded texels.
  spriteLoaded: assert property (@(posedge Clk) disable iff (rst)
    isZombie |-> !$isunknown(spriteColor));

endmodule

`default_nettype wire

//--- rtl/colorMapper.sv
`timescale 1ns/1ps
`default_nettype none

module colorMapper (
  input  logic Clk,
  input  logic rst,
  input  zombieTypes_pkg::scanPos_t scanDelayed,
  input  logic isZombie,
  input  zombieTypes_pkg::rgb_t spriteColor,
  output zombieTypes_pkg::pixelOut_t pixel
);

  localparam zombieTypes_pkg::scanPos_t SCAN_IDLE = '{
    x:     '0,
    y:     '0,
    hsync: 1'b1,
    vsync: 1'b1,
    blank: 1'b1
  };

  // The port carries the raw scanner output; this register lines it
  // up with the sprite table, which needs one cycle for the RAM read.
  zombieTypes_pkg::scanPos_t scanAligned;

  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      scanAligned <= SCAN_IDLE;
      pixel.pos <= SCAN_IDLE;
      pixel.color <= zombieTypes_pkg::COLOR_BLACK;
    end
    else
    begin
      scanAligned <= scanDelayed;
      pixel.pos <= scanAligned;
      if (scanAligned.blank)
        pixel.color <= zombieTypes_pkg::COLOR_BLACK; // Porch and sync.
      else if (isZombie)
        pixel.color <= spriteColor;
      else
        pixel.color <= zombieTypes_pkg::COLOR_WHITE;
    end
  end

endmodule

`default_nettype wire

//--- rtl/zombieDisplay.sv
`timescale 1ns/1ps
`default_nettype none

`include "zombie_settings.svh"

module zombieDisplay (
  input  logic Clk,
  input  logic rst,
  input  zombieTypes_pkg::zombieState_t zombies [`ZOMBIE_COUNT],
  input  zombieTypes_pkg::spriteWrite_t spriteLoad,
  output zombieTypes_pkg::pixelOut_t pixel
);

  zombieTypes_pkg::scanPos_t scan;
  zombieTypes_pkg::rgb_t spriteColor;
  logic isZombie;

  vgaScanner scanner0 (
    .Clk(Clk),
    .rst(rst),
    .scan(scan)
  );

  zombieSpriteTable spriteTable0 (
    .Clk(Clk),
    .rst(rst),
    .scan(scan),
    .zombies(zombies),
    .spriteLoad(spriteLoad),
    .isZombie(isZombie),
    .spriteColor(spriteColor)
  );

  // Delay to match the sprite table happens inside the mapper.
  colorMapper colorMapper0 (
    .Clk(Clk),
    .rst(rst),
    .scanDelayed(scan),
    .isZombie(isZombie),
    .spriteColor(spriteColor),
    .pixel(pixel)
  );

endmodule

`default_nettype wire

//--- test/zombieDisplay_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "zombie_settings.svh"

module zombieDisplay_tb;

  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int TEXELS = `SPRITE_SIZE * `SPRITE_SIZE;
  // Reset, 4096 texel writes and two frames come to about 844k cycles.
  localparam int CYCLE_LIMIT = 900000;

  logic Clk = 1'b0;
  logic rst;
  zombieTypes_pkg::zombieState_t zombies [`ZOMBIE_COUNT];
  zombieTypes_pkg::spriteWrite_t spriteLoad;
  zombieTypes_pkg::pixelOut_t pixel;

  logic [23:0] texels [4 * TEXELS]; // Face major, then row, then column.
  zombieTypes_pkg::zombieState_t zombiesLast [`ZOMBIE_COUNT];
  zombieTypes_pkg::zombieState_t zombiesUsed [`ZOMBIE_COUNT]; // States seen by the DUT.

  integer seed = 6077;
  int faceBase = 0;
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int settleCount = 0;
  int expX = 0;
  int expY = 0;

  zombieDisplay dut0 (
    .Clk(Clk),
    .rst(rst),
    .zombies(zombies),
    .spriteLoad(spriteLoad),
    .pixel(pixel)
  );

  initial
  begin
    forever #10 Clk = ~Clk;
  end

  task automatic compareField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic checkPixel(input int x, input int y, input logic hs, input logic vs,
                            input logic bl, input logic [23:0] color);
    compareField("pixel.pos.x", 32'(pixel.pos.x), 32'(x));
    compareField("pixel.pos.y", 32'(pixel.pos.y), 32'(y));
    compareField("pixel.pos.hsync", 32'(pixel.pos.hsync), 32'(hs));
    compareField("pixel.pos.vsync", 32'(pixel.pos.vsync), 32'(vs));
    compareField("pixel.pos.blank", 32'(pixel.pos.blank), 32'(bl));
    compareField("pixel.color", {8'd0, pixel.color}, {8'd0, color});
  endtask

  // First box in index order decides the pixel.
  function automatic logic [23:0] modelColor(input int x, input int y);
    int zx;
    int zy;
    int addr;
    if ((x >= `H_ACTIVE) || (y >= `V_ACTIVE))
      return 24'h000000;
    for (int i = 0; i < `ZOMBIE_COUNT; i++)
    begin
      zx = int'(zombiesUsed[i].x);
      zy = int'(zombiesUsed[i].y);
      if ((x >= zx) && (x < zx + `SPRITE_SIZE) && (y >= zy) && (y < zy + `SPRITE_SIZE))
      begin
        if (!zombiesUsed[i].live)
          return 24'hFFFFFF; // Dead, but still on top.
        addr = int'(zombiesUsed[i].face) * TEXELS + (y - zy) * `SPRITE_SIZE + (x - zx);
        return texels[addr];
      end
    end
    return 24'hFFFFFF;
  endfunction

  task automatic loadSprites();
    zombieTypes_pkg::spriteWrite_t w;
    for (int f = 0; f < 4; f++)
    begin
      for (int a = 0; a < TEXELS; a++)
      begin
        @(posedge Clk);
        w.we = 1'b1;
        w.face = zombieTypes_pkg::zombieFace_t'(2'(f));
        w.addr = `SPRITE_ADDR_WIDTH'(a);
        w.data = 24'($random(seed));
        texels[f * TEXELS + a] = w.data;
        spriteLoad <= w;
      end
    end
    @(posedge Clk);
    spriteLoad <= '0;
  endtask

  // Zombie 1 always overlaps zombie 0; the second set uses the remaining faces.
  task automatic placeZombies(input logic second);
    int baseX;
    int baseY;
    zombieTypes_pkg::zombieState_t z [`ZOMBIE_COUNT];
    baseX = $unsigned($random(seed)) % 560;
    baseY = $unsigned($random(seed)) % 400;
    z[0].x = `COORD_WIDTH'(baseX);
    z[0].y = `COORD_WIDTH'(baseY);
    z[1].x = `COORD_WIDTH'(baseX + 1 + ($unsigned($random(seed)) % 31));
    z[1].y = `COORD_WIDTH'(baseY + 1 + ($unsigned($random(seed)) % 31));
    z[2].x = `COORD_WIDTH'($unsigned($random(seed)) % 600);
    z[2].y = `COORD_WIDTH'($unsigned($random(seed)) % 440);
    z[0].live = !second;
    z[1].live = 1'b1;
    z[2].live = second;
    z[0].face = zombieTypes_pkg::zombieFace_t'(2'(faceBase + (second ? 1 : 0)));
    z[1].face = zombieTypes_pkg::zombieFace_t'(2'(faceBase + (second ? 3 : 1)));
    z[2].face = zombieTypes_pkg::zombieFace_t'(2'(faceBase + 2));
    for (int i = 0; i < `ZOMBIE_COUNT; i++)
      zombies[i] <= z[i];
  endtask

  always @(posedge Clk)
  begin
    zombiesUsed <= zombiesLast;
    zombiesLast <= zombies;
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Output is stable at the falling edge.
  always @(negedge Clk)
  begin
    if (rst || (settleCount < 2))
    begin
      if (!rst)
        settleCount = settleCount + 1;
      checkPixel(0, 0, 1'b1, 1'b1, 1'b1, 24'h000000); // Idle after reset.
    end
    else
    begin
      checkPixel(expX, expY,
                 !((expX >= `H_ACTIVE + `H_FRONT) && (expX < `H_ACTIVE + `H_FRONT + `H_SYNC)),
                 !((expY >= `V_ACTIVE + `V_FRONT) && (expY < `V_ACTIVE + `V_FRONT + `V_SYNC)),
                 (expX >= `H_ACTIVE) || (expY >= `V_ACTIVE),
                 modelColor(expX, expY));
      expX = expX + 1;
      if (expX == `H_TOTAL)
      begin
        expX = 0;
        expY = (expY == `V_TOTAL - 1) ? 0 : expY + 1;
      end
    end
  end

  initial
  begin
    rst <= 1'b1;
    spriteLoad <= '0;
    for (int i = 0; i < `ZOMBIE_COUNT; i++)
      zombies[i] <= '0; // Dead at the origin while loading.
    faceBase = $unsigned($random(seed)) % 4;
    repeat (4) @(posedge Clk);
    rst <= 1'b0;
    loadSprites();
    placeZombies(1'b0);
    repeat (FRAME_CYCLES) @(posedge Clk);
    placeZombies(1'b1);
    repeat (FRAME_CYCLES + 3) @(posedge Clk);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/zombieTypes_pkg.sv
rtl/vgaScanner.sv
rtl/spriteRam.sv
rtl/zombieSpriteTable.sv
rtl/colorMapper.sv
rtl/zombieDisplay.sv
test/zombieDisplay_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= zombieDisplay_tb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
